// File: fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// byte address and instruction word widths
`define ADDR_BITS 32
`define WORD_BITS 32

// one cache line is four instruction words
`define LINE_BITS 128

// number of direct-mapped instruction cache lines
`define CACHE_SIZE 16

// number of 2-bit counters in the branch history table
`define BHT_SIZE 32

`endif

// File: fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

  // pc split into tag, index and byte offset within a line
  localparam int OFFSET_BITS = $clog2(`LINE_BITS / 8);
  localparam int INDEX_BITS = $clog2(`CACHE_SIZE);
  localparam int TAG_BITS = `ADDR_BITS - INDEX_BITS - OFFSET_BITS;

  typedef logic [`ADDR_BITS-1:0] addr_t;
  typedef logic [`WORD_BITS-1:0] inst_t;
  typedef logic [`LINE_BITS-1:0] line_t;
  typedef logic [TAG_BITS-1:0] tag_t;
  typedef logic [INDEX_BITS-1:0] index_t;

  // fetcher is either waiting for a miss or has a line read in flight
  typedef enum logic {
    IDLE,
    INTERACTING
  } fetch_state_t;

endpackage

// File: mem_port_if.sv
`timescale 1ns/100ps

interface mem_port_if;
  import fetch_pkg::*;

  // requester holds valid and addr until it sees ready
  logic valid;
  addr_t addr;
  // ready is a one-cycle pulse and line is only meaningful with it
  logic ready;
  line_t line;

  modport requester (
    output valid,
    output addr,
    input ready,
    input line
  );

  modport server (
    input valid,
    input addr,
    output ready,
    output line
  );
endinterface

// File: inst_fetcher.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module inst_fetcher (
  input logic clk,
  input logic reset_from_rob_bus,
  mem_port_if.requester mem,
  output fetch_pkg::addr_t pred_pc,
  output fetch_pkg::inst_t pred_inst,
  input fetch_pkg::addr_t pred_next_pc,
  input logic issue_full,
  input logic redirect,
  input fetch_pkg::addr_t redirect_pc,
  output logic issue_valid,
  output fetch_pkg::addr_t issue_pc,
  output fetch_pkg::addr_t issue_next_pc,
  output fetch_pkg::inst_t issue_inst
);
  import fetch_pkg::*;

  // direct-mapped cache storage
  tag_t cache_tags [`CACHE_SIZE];
  line_t cache_lines [`CACHE_SIZE];
  logic [`CACHE_SIZE-1:0] valid_bits;

  fetch_state_t state;
  addr_t pc;

  tag_t tag;
  index_t index;
  logic [OFFSET_BITS-3:0] word_sel;
  logic hit;
  inst_t line_word;
  logic fill_match;
  logic fill_en;

  assign tag = pc[`ADDR_BITS-1 -: TAG_BITS];
  assign index = pc[OFFSET_BITS +: INDEX_BITS];
  // word within the line with the byte offset bits below it ignored
  assign word_sel = pc[OFFSET_BITS-1:2];
  assign hit = valid_bits[index] && (cache_tags[index] == tag);
  assign line_word = cache_lines[index][word_sel * `WORD_BITS +: `WORD_BITS];

  // a redirect while the read is in flight leaves the returned line stale
  assign fill_match = mem.addr[`ADDR_BITS-1:OFFSET_BITS] == pc[`ADDR_BITS-1:OFFSET_BITS];
  assign fill_en = (state == INTERACTING) && mem.ready && fill_match;

  assign mem.valid = (state == INTERACTING);

  // predictor sees the same pc and word as the issuer
  assign pred_pc = pc;
  assign pred_inst = issue_inst;

  assign issue_valid = hit;
  assign issue_pc = pc;
  assign issue_next_pc = pred_next_pc;
  assign issue_inst = hit ? line_word : '0;

  // pc moves on an accepted issue, redirect takes precedence
  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (hit && !issue_full) begin
      pc <= pred_next_pc;
    end
  end

  // miss FSM and line valid bits
  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      state <= IDLE;
      valid_bits <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (!hit && !redirect) begin
            state <= INTERACTING;
          end
        end
        INTERACTING: begin
          if (mem.ready) begin
            state <= IDLE;
          end
          if (fill_en) begin
            valid_bits[index] <= 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // request address and line payload
  always_ff @(posedge clk) begin
    if (state == IDLE && !hit) begin
      mem.addr <= pc;
    end
    if (fill_en) begin
      cache_tags[index] <= tag;
      cache_lines[index] <= mem.line;
    end
  end
endmodule

// File: branch_predictor.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module branch_predictor (
  input logic clk,
  input logic reset_from_rob_bus,
  input fetch_pkg::addr_t pred_pc,
  input fetch_pkg::inst_t pred_inst,
  output fetch_pkg::addr_t pred_next_pc,
  input logic br_update_valid,
  input fetch_pkg::addr_t br_update_pc,
  input logic br_update_taken
);
  import fetch_pkg::*;

  localparam int BHT_IDX_BITS = $clog2(`BHT_SIZE);
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  logic [1:0] bht [`BHT_SIZE];

  logic [BHT_IDX_BITS-1:0] pred_idx;
  logic [BHT_IDX_BITS-1:0] upd_idx;
  addr_t j_imm;
  addr_t b_imm;

  // counters are indexed by word address
  assign pred_idx = pred_pc[2 +: BHT_IDX_BITS];
  assign upd_idx = br_update_pc[2 +: BHT_IDX_BITS];

  assign j_imm = {{12{pred_inst[31]}}, pred_inst[19:12], pred_inst[20],
                  pred_inst[30:21], 1'b0};
  assign b_imm = {{20{pred_inst[31]}}, pred_inst[7], pred_inst[30:25],
                  pred_inst[11:8], 1'b0};

  always_comb begin
    pred_next_pc = pred_pc + 32'd4;
    if (pred_inst[6:0] == OP_JAL) begin
      pred_next_pc = pred_pc + j_imm;
    end else if (pred_inst[6:0] == OP_BRANCH && bht[pred_idx][1]) begin
      // upper counter bit set means taken
      pred_next_pc = pred_pc + b_imm;
    end
  end

  // saturating update from the reorder buffer
  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      for (int i = 0; i < `BHT_SIZE; i++) begin
        bht[i] <= 2'b01;
      end
    end else if (br_update_valid) begin
      if (br_update_taken && bht[upd_idx] != 2'b11) begin
        bht[upd_idx] <= bht[upd_idx] + 2'b01;
      end else if (!br_update_taken && bht[upd_idx] != 2'b00) begin
        bht[upd_idx] <= bht[upd_idx] - 2'b01;
      end
    end
  end
endmodule

// File: data_line_reader.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module data_line_reader (
  input logic clk,
  input logic reset_from_rob_bus,
  mem_port_if.requester mem,
  input logic load_req,
  input fetch_pkg::addr_t load_addr,
  output logic load_busy,
  output logic load_done,
  output fetch_pkg::line_t load_line
);
  import fetch_pkg::*;

  // busy doubles as the memory valid with only one request outstanding
  assign mem.valid = load_busy;

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      load_busy <= 1'b0;
      load_done <= 1'b0;
    end else begin
      load_done <= load_busy && mem.ready;
      if (!load_busy && load_req) begin
        load_busy <= 1'b1;
      end else if (mem.ready) begin
        load_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!load_busy && load_req) begin
      mem.addr <= {load_addr[`ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    end
    if (load_busy && mem.ready) begin
      load_line <= mem.line;
    end
  end
endmodule

// File: mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
  input logic clk,
  input logic reset_from_rob_bus,
  mem_port_if.server fetch_port,
  mem_port_if.server load_port,
  output logic mem_valid,
  output fetch_pkg::addr_t mem_addr,
  input logic mem_ready,
  input fetch_pkg::line_t mem_line
);
  import fetch_pkg::*;

  logic held;
  logic grant_fetch;
  logic pick_fetch;

  // while a grant is held the owner is fixed, otherwise fetch wins ties
  assign pick_fetch = held ? grant_fetch : fetch_port.valid;

  assign mem_valid = pick_fetch ? fetch_port.valid : load_port.valid;
  assign mem_addr = pick_fetch ? fetch_port.addr : load_port.addr;

  // ready goes only to the owner, line can go to both
  assign fetch_port.ready = mem_ready && pick_fetch;
  assign load_port.ready = mem_ready && !pick_fetch;
  assign fetch_port.line = mem_line;
  assign load_port.line = mem_line;

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      held <= 1'b0;
      grant_fetch <= 1'b0;
    end else if (held) begin
      if (mem_ready) begin
        held <= 1'b0;
      end
    end else if (mem_valid) begin
      // memory answers at least one cycle after valid, so no ready here
      held <= 1'b1;
      grant_fetch <= pick_fetch;
    end
  end
endmodule

// File: fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
  input logic clk,
  input logic reset_from_rob_bus,
  input logic issue_full,
  input logic redirect,
  input fetch_pkg::addr_t redirect_pc,
  output logic issue_valid,
  output fetch_pkg::addr_t issue_pc,
  output fetch_pkg::addr_t issue_next_pc,
  output fetch_pkg::inst_t issue_inst,
  input logic br_update_valid,
  input logic br_update_taken,
  input fetch_pkg::addr_t br_update_pc,
  input logic load_req,
  input fetch_pkg::addr_t load_addr,
  output logic load_busy,
  output logic load_done,
  output fetch_pkg::line_t load_line,
  output logic mem_valid,
  output fetch_pkg::addr_t mem_addr,
  input logic mem_ready,
  input fetch_pkg::line_t mem_line
);
  import fetch_pkg::*;

  addr_t pred_pc;
  inst_t pred_inst;
  addr_t pred_next_pc;

  // one line-read port per requester
  mem_port_if fetch_mem ();
  mem_port_if load_mem ();

  inst_fetcher u_fetcher (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .mem(fetch_mem.requester),
    .pred_pc(pred_pc),
    .pred_inst(pred_inst),
    .pred_next_pc(pred_next_pc),
    .issue_full(issue_full),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .issue_valid(issue_valid),
    .issue_pc(issue_pc),
    .issue_next_pc(issue_next_pc),
    .issue_inst(issue_inst)
  );

  branch_predictor u_predictor (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .pred_pc(pred_pc),
    .pred_inst(pred_inst),
    .pred_next_pc(pred_next_pc),
    .br_update_valid(br_update_valid),
    .br_update_pc(br_update_pc),
    .br_update_taken(br_update_taken)
  );

  data_line_reader u_reader (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .mem(load_mem.requester),
    .load_req(load_req),
    .load_addr(load_addr),
    .load_busy(load_busy),
    .load_done(load_done),
    .load_line(load_line)
  );

  mem_arbiter u_arbiter (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .fetch_port(fetch_mem.server),
    .load_port(load_mem.server),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_ready(mem_ready),
    .mem_line(mem_line)
  );
endmodule

// File: fetch_props.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_props (
  input logic clk,
  input logic reset_from_rob_bus,
  input logic issue_full,
  input logic redirect,
  input fetch_pkg::addr_t redirect_pc,
  input logic issue_valid,
  input fetch_pkg::addr_t issue_pc,
  input fetch_pkg::addr_t issue_next_pc,
  input fetch_pkg::inst_t issue_inst,
  input logic br_update_valid,
  input logic br_update_taken,
  input fetch_pkg::addr_t br_update_pc,
  input logic load_req,
  input fetch_pkg::addr_t load_addr,
  input logic load_busy,
  input logic load_done,
  input fetch_pkg::line_t load_line,
  input logic mem_valid,
  input fetch_pkg::addr_t mem_addr,
  input logic mem_ready,
  input logic fetch_req,
  input fetch_pkg::addr_t fetch_addr
);
  import fetch_pkg::*;

  localparam int CNT_IDX_BITS = $clog2(`BHT_SIZE);

  int unsigned fail_count = 0;
  logic [1:0] counters [`BHT_SIZE];
  logic [1:0] cnt_now;
  addr_t exp_pc;
  addr_t exp_next_pc;
  addr_t load_base;
  logic from_redirect;
  logic port_held;

  // word 7 of each 8-word group is jal +8, word 3 is beq -12, the rest addi
  function automatic inst_t expected_word(addr_t a);
    logic [11:0] imm;
    imm = a[13:2] ^ a[25:14] ^ {6'd0, a[31:26]};
    case (a[4:2])
      3'd7: return 32'h008000ef;
      3'd3: return 32'hfe000ae3;
      default: return {imm, 5'd0, 3'b000, a[6:2], 7'b0010011};
    endcase
  endfunction

  function automatic line_t expected_line(addr_t a);
    line_t l;
    for (int w = 0; w < `LINE_BITS / `WORD_BITS; w++) begin
      l[w*`WORD_BITS +: `WORD_BITS] = expected_word({a[31:4], w[1:0], 2'b00});
    end
    return l;
  endfunction

  assign cnt_now = counters[issue_pc[2 +: CNT_IDX_BITS]];

  always_comb begin
    exp_next_pc = issue_pc + 32'd4;
    if (issue_pc[4:2] == 3'd7) begin
      exp_next_pc = issue_pc + 32'd8;
    end else if (issue_pc[4:2] == 3'd3 && cnt_now >= 2'd2) begin
      exp_next_pc = issue_pc - 32'd12;
    end
  end

  // reference counter table, fed by the same update strobes
  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      for (int i = 0; i < `BHT_SIZE; i++) begin
        counters[i] <= 2'd1;
      end
    end else if (br_update_valid) begin
      if (br_update_taken && counters[br_update_pc[2 +: CNT_IDX_BITS]] != 2'd3) begin
        counters[br_update_pc[2 +: CNT_IDX_BITS]] <= counters[br_update_pc[2 +: CNT_IDX_BITS]] + 1;
      end else if (!br_update_taken && counters[br_update_pc[2 +: CNT_IDX_BITS]] != 2'd0) begin
        counters[br_update_pc[2 +: CNT_IDX_BITS]] <= counters[br_update_pc[2 +: CNT_IDX_BITS]] - 1;
      end
    end
  end

  // expected pc, grant ownership and load line address
  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      exp_pc <= '0;
      from_redirect <= 1'b0;
      port_held <= 1'b0;
    end else begin
      if (redirect) begin
        exp_pc <= redirect_pc;
        from_redirect <= 1'b1;
      end else if (issue_valid && !issue_full) begin
        exp_pc <= issue_next_pc;
        from_redirect <= 1'b0;
      end
      if (!port_held && mem_valid) begin
        port_held <= 1'b1;
      end else if (port_held && mem_ready) begin
        port_held <= 1'b0;
      end
      if (load_req && !load_busy) begin
        load_base <= {load_addr[31:4], 4'h0};
      end
    end
  end

  a_issue_inst: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    issue_valid |-> issue_inst == expected_word(issue_pc))
  else begin
    fail_count++;
    $error("mismatch at %0t: issue_inst %h at pc %h", $time, $sampled(issue_inst),
           $sampled(issue_pc));
  end

  a_next_pc: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    issue_valid |-> issue_next_pc == exp_next_pc)
  else begin
    fail_count++;
    $error("mismatch at %0t: issue_next_pc %h, expected %h", $time,
           $sampled(issue_next_pc), $sampled(exp_next_pc));
  end

  a_follow: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    issue_valid && !from_redirect |-> issue_pc == exp_pc)
  else begin
    fail_count++;
    $error("mismatch at %0t: issue_pc %h, expected %h", $time, $sampled(issue_pc),
           $sampled(exp_pc));
  end

  a_redirect_target: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    issue_valid && from_redirect |-> issue_pc == exp_pc)
  else begin
    fail_count++;
    $error("mismatch at %0t: issue_pc %h after redirect to %h", $time,
           $sampled(issue_pc), $sampled(exp_pc));
  end

  a_hold_when_full: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    issue_valid && issue_full && !redirect |=> $stable(issue_pc) && $stable(issue_inst))
  else begin
    fail_count++;
    $error("issue outputs changed while issue_full was high at %0t", $time);
  end

  a_load_line: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    load_done |-> load_line == expected_line(load_base))
  else begin
    fail_count++;
    $error("mismatch at %0t: load_line for %h", $time, $sampled(load_base));
  end

  a_fetch_first: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    !port_held && fetch_req && load_busy |-> mem_addr == fetch_addr)
  else begin
    fail_count++;
    $error("mismatch at %0t: mem_addr %h, fetch wanted %h", $time, $sampled(mem_addr),
           $sampled(fetch_addr));
  end

  a_reset_idle: assert property (@(posedge clk)
    reset_from_rob_bus |=> !mem_valid && !issue_valid && !load_busy && !load_done)
  else begin
    fail_count++;
    $error("outputs not idle after reset at %0t", $time);
  end

  a_mem_hold: assert property (@(posedge clk) disable iff (reset_from_rob_bus)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
  else begin
    fail_count++;
    $error("memory request dropped or changed before mem_ready at %0t", $time);
  end
endmodule

// File: tb_top.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module tb_top;
  import fetch_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int STIM_CYCLES = 2000;
  localparam int WATCHDOG_CYCLES = STIM_CYCLES * 4 + 100;

  logic clk;
  logic reset_from_rob_bus;
  logic issue_full;
  logic redirect;
  addr_t redirect_pc;
  logic issue_valid;
  addr_t issue_pc;
  addr_t issue_next_pc;
  inst_t issue_inst;
  logic br_update_valid;
  logic br_update_taken;
  addr_t br_update_pc;
  logic load_req;
  addr_t load_addr;
  logic load_busy;
  logic load_done;
  line_t load_line;
  logic mem_valid;
  addr_t mem_addr;
  logic mem_ready;
  line_t mem_line;

  logic [31:0] lfsr;
  logic mem_busy;
  int mem_wait;
  int loads_sent;
  int loads_done;
  int issued;
  int other_errors;

  fetch_top dut0 (.*);

  bind fetch_top fetch_props u_props (
    .*,
    .fetch_req(fetch_mem.valid),
    .fetch_addr(fetch_mem.addr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // jal +8 at word 7 of each group of 8 and beq -12 at word 3
  function automatic inst_t word_at(addr_t a);
    logic [11:0] imm;
    imm = a[13:2] ^ a[25:14] ^ {6'd0, a[31:26]};
    if (a[4:2] == 3'd7) begin
      return 32'h008000ef;
    end else if (a[4:2] == 3'd3) begin
      return 32'hfe000ae3;
    end
    return {imm, 5'd0, 3'b000, a[6:2], 7'b0010011};
  endfunction

  function automatic line_t line_at(addr_t a);
    line_t l;
    for (int w = 0; w < `LINE_BITS / `WORD_BITS; w++) begin
      l[w*`WORD_BITS +: `WORD_BITS] = word_at({a[31:4], 4'h0} + 32'(w * 4));
    end
    return l;
  endfunction

  // line memory with 1 to 4 cycles of latency and a one-cycle ready
  task automatic serve_memory();
    logic [31:0] rnd;
    if (mem_ready) begin
      mem_ready = 1'b0;
      mem_busy = 1'b0;
    end else if (mem_busy) begin
      mem_wait--;
      if (mem_wait == 0) begin
        mem_ready = 1'b1;
        mem_line = line_at(mem_addr);
      end
    end else if (mem_valid) begin
      rnd = random_bits(2);
      mem_wait = rnd[1:0] + 1;
      mem_busy = 1'b1;
    end
  endtask

  task automatic drive_inputs(input logic active);
    logic [31:0] rnd;
    if (load_done) begin
      loads_done++;
    end
    issue_full = active && random_bits(2) == 0;
    redirect = 1'b0;
    if (active && random_bits(5) == 0) begin
      redirect = 1'b1;
      rnd = random_bits(8);
      redirect_pc = {22'd0, rnd[7:0], 2'b00};
    end
    // branches accepted at the coming edge go back as updates
    br_update_valid = 1'b0;
    if (issue_valid && !issue_full && !redirect) begin
      issued++;
      if (issue_inst[6:0] == 7'b1100011) begin
        rnd = random_bits(1);
        br_update_valid = 1'b1;
        br_update_pc = issue_pc;
        br_update_taken = rnd[0];
      end
    end
    load_req = 1'b0;
    if (active && !load_busy && random_bits(3) == 0) begin
      rnd = random_bits(10);
      load_req = 1'b1;
      load_addr = {22'd0, rnd[9:0]};
      loads_sent++;
    end
  endtask

  initial begin
    lfsr = 32'he5e3_0b52;
    clk = 1'b0;
    reset_from_rob_bus = 1'b1;
    issue_full = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    br_update_valid = 1'b0;
    br_update_taken = 1'b0;
    br_update_pc = '0;
    load_req = 1'b0;
    load_addr = '0;
    mem_ready = 1'b0;
    mem_line = '0;
    mem_busy = 1'b0;
    mem_wait = 0;
    loads_sent = 0;
    loads_done = 0;
    issued = 0;
    other_errors = 0;
    repeat (3) @(negedge clk);
    reset_from_rob_bus = 1'b0;
    for (int c = 0; c < STIM_CYCLES; c++) begin
      @(negedge clk);
      serve_memory();
      drive_inputs(1'b1);
    end
    // drain the last load before judging
    do begin
      @(negedge clk);
      serve_memory();
      drive_inputs(1'b0);
    end while (load_busy || load_done);
    if (issued == 0) begin
      other_errors++;
      $display("no instruction was issued during the run");
    end
    if (loads_done != loads_sent) begin
      other_errors++;
      $display("%0d loads were sent but %0d load_done pulses came back", loads_sent,
               loads_done);
    end
    $display("assertion failures: %0d, other errors: %0d", dut0.u_props.fail_count,
             other_errors);
    if (dut0.u_props.fail_count == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end
endmodule

// File: flist.f
+incdir+.
fetch_pkg.sv
mem_port_if.sv
inst_fetcher.sv
branch_predictor.sv
data_line_reader.sv
mem_arbiter.sv
fetch_top.sv
fetch_props.sv
tb_top.sv

// File: Makefile
TOP ?= tb_top
FLIST ?= flist.f
LOG ?= sim.log
TIMEOUT ?= 600
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
ERROR_LIMIT ?= 1000000

FAIL_MSG = TEST RESULT: FAIL
PASS_MSG = TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	-timeout $(TIMEOUT) ./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) \
		> $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
